//--- filelist.f
+incdir+src
src/mduPkg.sv
src/mduControl.sv
src/mulUnit.sv
src/divUnit.sv
src/hiLoFile.sv
src/mduTop.sv
testbench/mduTb_asserts.sv
testbench/mduTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mduTb
RTL_TOP   ?= mduTop
FLIST     ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/mduTb.sv
`default_nettype none

`include "mdu_macros.svh"

module mduTb import mduPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// Cycles for one arithmetic run, issue plus latency
	localparam int mulRun  = `MDU_MUL_CYCLES + 2;
	localparam int divRun  = `MDU_DIV_CYCLES + 2;
	localparam int fastRun = `MDU_FASTDIV_CYCLES + 2;

	// Reset 7, six reports, move 12, busy 10, clear 17
	localparam int fixedCycles = 7 + 6 + 12 + 10 + 17;
	// 13 multiplies, 12 divides and 6 fast divides in all
	localparam int testCycles  = fixedCycles + 13 * mulRun + 12 * divRun + 6 * fastRun;
	localparam int cycleLimit  = testCycles * 2;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  start;
	logic                  clr;
	mduReqT                req;
	hiLoT                  hiLo;
	logic [`MDU_WIDTH-1:0] rdData;
	logic                  busy;
	int                    seed;
	int                    cycles = 0;
	int                    nPass;
	int                    nFail;
	int                    errBase;

	always #5 clk = ~clk;

	mduTop i_dut (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.start  (start),
		.clr    (clr),
		.hiLo   (hiLo),
		.rdData (rdData),
		.busy   (busy)
	);

	////////////////////////////////////////
	// Run limit
	////////////////////////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: no finish after %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// One cycle of a request and back to idle
	task automatic issue(input mduOpT op, input logic [31:0] a, input logic [31:0] b,
		input logic st);
		@(negedge clk);
		req.op   = op;
		req.srcA = a;
		req.srcB = b;
		start    = st;
		@(negedge clk);
		start  = 1'b0;
		req.op = opNone;
	endtask

	// Arithmetic op that waits for busy to fall
	task automatic runOp(input mduOpT op, input logic [31:0] a, input logic [31:0] b);
		issue(op, a, b, 1'b1);
		while (busy) begin
			@(negedge clk);
		end
	endtask

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	// Report by the assertion error count seen during the test
	task automatic reportTest(input string name);
		int errNow;
		// Let the checks on the closing edge of the test run
		@(negedge clk);
		errNow = i_dut.i_asserts.errCnt;
		if (errNow > errBase) begin
			nFail++;
			$display("Fail at %0t: %s raised %0d assertion errors", $time, name,
				errNow - errBase);
		end else begin
			nPass++;
			$display("Test %s ok", name);
		end
		errBase = errNow;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	initial begin
		seed    = 32'h2559815b;
		nPass   = 0;
		nFail   = 0;
		errBase = 0;
		rst     = 1'b1;
		start   = 1'b0;
		clr     = 1'b0;
		req     = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		reportTest("reset");

		// Corners first and random operands after
		runOp(opMult, 32'h8000_0000, 32'h8000_0000);
		runOp(opMult, 32'hffff_ffff, 32'hffff_ffff);
		runOp(opMult, 32'h7fff_ffff, 32'h8000_0000);
		runOp(opMultu, 32'hffff_ffff, 32'hffff_ffff);
		for (int i = 0; i < 4; i++) begin
			runOp(opMult, randWord(), randWord());
			runOp(opMultu, randWord(), randWord());
		end
		reportTest("multiply");

		runOp(opDiv, 32'h1234_5678, 32'h0);
		runOp(opDivu, 32'h8765_4321, 32'h0);
		runOp(opFastDiv, 32'hffff_fff9, 32'h0);
		runOp(opDiv, 32'h8000_0000, 32'hffff_ffff);
		runOp(opFastDiv, 32'h8000_0000, 32'hffff_ffff);
		runOp(opDivu, 32'h8000_0000, 32'hffff_ffff);
		runOp(opDiv, 32'hffff_fff9, 32'h2);
		runOp(opFastDiv, 32'h7, 32'hffff_fffe);
		for (int i = 0; i < 3; i++) begin
			runOp(opDiv, randWord(), randWord());
			runOp(opDivu, randWord(), randWord());
			runOp(opFastDiv, randWord(), randWord() & 32'h0000_ffff);
		end
		reportTest("divide");

		issue(opMthi, 32'hcafe_0001, 32'h0, 1'b0);
		issue(opMtlo, 32'hbeef_0002, 32'h0, 1'b0);
		issue(opMfhi, 32'h0, 32'h0, 1'b0);
		issue(opMflo, 32'h0, 32'h0, 1'b0);
		issue(opNone, 32'h0, 32'h0, 1'b0);
		issue(opMult, 32'h3, 32'h4, 1'b0);
		reportTest("move");

		// Everything issued here lands while a divide runs
		issue(opDiv, randWord(), 32'h7, 1'b1);
		issue(opMult, randWord(), randWord(), 1'b1);
		issue(opMthi, 32'h1111_1111, 32'h0, 1'b0);
		issue(opMtlo, 32'h2222_2222, 32'h0, 1'b0);
		issue(opFastDiv, randWord(), randWord(), 1'b1);
		while (busy) begin
			@(negedge clk);
		end
		reportTest("busy");

		// Abort a divide part way
		issue(opDivu, randWord(), randWord(), 1'b1);
		repeat (2) @(negedge clk);
		clr = 1'b1;
		@(negedge clk);
		clr = 1'b0;
		repeat (12) @(negedge clk);
		runOp(opMultu, randWord(), randWord());
		reportTest("clear");

		$display("Tests %0d, passed %0d, failed %0d", nPass + nFail, nPass, nFail);
		if (nFail == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/mduTb_asserts.sv
`default_nettype none

`include "mdu_macros.svh"

module mduAsserts import mduPkg::*; (
	input wire logic                  clk,
	input wire logic                  rst,
	input wire logic                  clr,
	input wire logic                  start,
	input wire logic                  busy,
	input wire logic                  commit,
	input wire mduReqT                req,
	input wire hiLoT                  hiLo,
	input wire logic [`MDU_WIDTH-1:0] rdData
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int W = `MDU_WIDTH;

	int                errCnt = 0;
	int                modelCnt;
	hiLoT              modelHiLo;
	hiLoT              pending;
	logic              modelBusy;
	logic              accOk;
	logic [W-1:0]      expRead;

	// Cycles from start to commit, zero for non-arithmetic codes
	function automatic int latency(input mduOpT op);
		case (op)
			opMult, opMultu: return `MDU_MUL_CYCLES;
			opDiv, opDivu:   return `MDU_DIV_CYCLES;
			opFastDiv:       return `MDU_FASTDIV_CYCLES;
			default:         return 0;
		endcase
	endfunction

	// Expected HI/LO straight from the arithmetic rules
	function automatic hiLoT refResult(input mduReqT r);
		logic signed [W-1:0] sa;
		logic signed [W-1:0] sb;
		hiLoT                res;
		sa = r.srcA;
		sb = r.srcB;
		res = '0;
		if (r.op == opMult) begin
			res = hiLoT'(longint'(sa) * longint'(sb));
		end else if (r.op == opMultu) begin
			res = hiLoT'({32'h0, r.srcA} * {32'h0, r.srcB});
		end else if (r.srcB == '0) begin
			res.lo = '1;
			res.hi = r.srcA;
		end else if (r.op == opDivu) begin
			res.lo = r.srcA / r.srcB;
			res.hi = r.srcA % r.srcB;
		end else if (r.srcA == 32'h8000_0000 && r.srcB == '1) begin
			// Signed overflow case
			res.lo = r.srcA;
			res.hi = '0;
		end else begin
			res.lo = sa / sb;
			res.hi = sa % sb;
		end
		return res;
	endfunction

	////////////////////////////////////////
	// Shadow model of the unit
	////////////////////////////////////////

	assign modelBusy = (modelCnt != 0);
	assign accOk     = start && !modelBusy && (latency(req.op) != 0) && !clr;

	always_comb begin
		case (req.op)
			opMfhi:  expRead = modelHiLo.hi;
			opMflo:  expRead = modelHiLo.lo;
			default: expRead = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			modelCnt  <= 0;
			modelHiLo <= '0;
		end else if (accOk) begin
			modelCnt <= latency(req.op);
			pending  <= refResult(req);
		end else if (modelBusy) begin
			modelCnt <= modelCnt - 1;
			// Last count loads the result
			if (modelCnt == 1) begin
				modelHiLo <= pending;
			end
		end else if (req.op == opMthi) begin
			modelHiLo.hi <= req.srcA;
		end else if (req.op == opMtlo) begin
			modelHiLo.lo <= req.srcA;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	aBusy: assert property (@(posedge clk) disable iff (rst) busy == modelBusy)
		else begin $error("busy differs from model"); errCnt++; end

	aCommit: assert property (@(posedge clk) disable iff (rst)
		commit == (modelCnt == 1 && !clr))
		else begin $error("commit pulse misplaced"); errCnt++; end

	aHiLo: assert property (@(posedge clk) disable iff (rst) hiLo == modelHiLo)
		else begin $error("HI/LO mismatch"); errCnt++; end

	aRead: assert property (@(posedge clk) disable iff (rst) rdData == expRead)
		else begin $error("rdData mismatch"); errCnt++; end

	// Exact latency per class
	aMulLat: assert property (@(posedge clk) disable iff (rst || clr)
		(accOk && (req.op == opMult || req.op == opMultu))
		|=> busy [*`MDU_MUL_CYCLES] ##1 !busy)
		else begin $error("multiply latency wrong"); errCnt++; end

	aDivLat: assert property (@(posedge clk) disable iff (rst || clr)
		(accOk && (req.op == opDiv || req.op == opDivu))
		|=> busy [*`MDU_DIV_CYCLES] ##1 !busy)
		else begin $error("divide latency wrong"); errCnt++; end

	aFastLat: assert property (@(posedge clk) disable iff (rst || clr)
		(accOk && req.op == opFastDiv)
		|=> busy [*`MDU_FASTDIV_CYCLES] ##1 !busy)
		else begin $error("fast divide latency wrong"); errCnt++; end

	aClr: assert property (@(posedge clk) disable iff (rst)
		clr |=> !busy && !commit && hiLo == '0)
		else begin $error("clear did not abort"); errCnt++; end

	aRst: assert property (@(posedge clk) rst |=> !busy && !commit)
		else begin $error("unit active after reset"); errCnt++; end

endmodule

bind mduTop mduAsserts i_asserts (
	.clk    (clk),
	.rst    (rst),
	.clr    (clr),
	.start  (start),
	.busy   (busy),
	.commit (commit),
	.req    (req),
	.hiLo   (hiLo),
	.rdData (rdData)
);

`default_nettype wire

//--- src/mduTop.sv
`default_nettype none

`include "mdu_macros.svh"

module mduTop import mduPkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire mduReqT             req,
	input  wire logic               start,
	input  wire logic               clr,
	output hiLoT                    hiLo,
	output logic [`MDU_WIDTH-1:0]   rdData,
	output logic                    busy
);

	logic   mulStart;
	logic   divStart;
	logic   divSigned;
	logic   mulSigned;
	logic   commit;
	resSelT commitSel;
	hiLoT   product;
	hiLoT   divRes;

	// Only MULT is signed among the multiplies
	assign mulSigned = (req.op == opMult);

	////////////////////////////////////////
	// Control and datapaths
	////////////////////////////////////////

	mduControl i_control (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.start     (start),
		.op        (req.op),
		.mulStart  (mulStart),
		.divStart  (divStart),
		.divSigned (divSigned),
		.commit    (commit),
		.commitSel (commitSel),
		.busy      (busy)
	);

	mulUnit i_mul (
		.clk      (clk),
		.rst      (rst),
		.mulStart (mulStart),
		.isSigned (mulSigned),
		.srcA     (req.srcA),
		.srcB     (req.srcB),
		.product  (product)
	);

	divUnit i_div (
		.clk       (clk),
		.rst       (rst),
		.divStart  (divStart),
		.divSigned (divSigned),
		.srcA      (req.srcA),
		.srcB      (req.srcB),
		.divRes    (divRes)
	);

	// Result registers and read port
	hiLoFile i_hiLo (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.busy      (busy),
		.req       (req),
		.commit    (commit),
		.commitSel (commitSel),
		.product   (product),
		.divRes    (divRes),
		.hiLo      (hiLo),
		.rdData    (rdData)
	);

endmodule

`default_nettype wire

//--- src/hiLoFile.sv
`default_nettype none

`include "mdu_macros.svh"

module hiLoFile import mduPkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   clr,
	input  wire logic                   busy,
	input  wire mduReqT                 req,
	input  wire logic                   commit,
	input  wire resSelT                 commitSel,
	input  wire hiLoT                   product,
	input  wire hiLoT                   divRes,
	output hiLoT                        hiLo,
	output logic [`MDU_WIDTH-1:0]       rdData
);

	hiLoT selRes;

	// Result from whichever datapath ran
	assign selRes = (commitSel == selDiv) ? divRes : product;

	////////////////////////////////////////
	// HI and LO registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			hiLo <= '0;
		end else if (commit) begin
			hiLo <= selRes;
		end else if (!busy) begin
			// Move-to writes, dropped while busy since the pipe stalls
			if (req.op == opMthi) begin
				hiLo.hi <= req.srcA;
			end
			if (req.op == opMtlo) begin
				hiLo.lo <= req.srcA;
			end
		end
	end

	////////////////////////////////////////
	// Move-from read
	////////////////////////////////////////

	always_comb begin
		case (req.op)
			opMfhi:  rdData = hiLo.hi;
			opMflo:  rdData = hiLo.lo;
			default: rdData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/divUnit.sv
`default_nettype none

`include "mdu_macros.svh"

module divUnit import mduPkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  divStart,
	input  wire logic                  divSigned,
	input  wire logic [`MDU_WIDTH-1:0] srcA,
	input  wire logic [`MDU_WIDTH-1:0] srcB,
	output hiLoT                       divRes
);

	localparam int W = `MDU_WIDTH;

	logic [W-1:0] magA;
	logic [W-1:0] magB;
	logic [W-1:0] safeB;
	logic [W-1:0] magQ;
	logic [W-1:0] magR;
	logic         negA;
	logic         negB;
	logic         divZero;
	logic         overflow;
	hiLoT         nextRes;

	////////////////////////////////////////
	// Magnitude division
	////////////////////////////////////////

	assign negA = divSigned && srcA[W-1];
	assign negB = divSigned && srcB[W-1];
	assign magA = negA ? -srcA : srcA;
	assign magB = negB ? -srcB : srcB;

	// Keep the divider defined for a zero divisor
	assign safeB = (magB == '0) ? {{(W-1){1'b0}}, 1'b1} : magB;
	assign magQ  = magA / safeB;
	assign magR  = magA % safeB;

	// Special cases
	assign divZero  = (srcB == '0);
	assign overflow = divSigned && (srcA == {1'b1, {(W-1){1'b0}}}) && (srcB == '1);

	always_comb begin
		if (divZero) begin
			// All-ones quotient, dividend back as remainder
			nextRes.lo = '1;
			nextRes.hi = srcA;
		end else if (overflow) begin
			nextRes.lo = srcA;
			nextRes.hi = '0;
		end else begin
			// Truncate toward zero, remainder follows the dividend
			nextRes.lo = (negA ^ negB) ? -magQ : magQ;
			nextRes.hi = negA ? -magR : magR;
		end
	end

	// Result captured at start and held until the next one
	always_ff @(posedge clk) begin
		if (rst) begin
			divRes <= '0;
		end else if (divStart) begin
			divRes <= nextRes;
		end
	end

endmodule

`default_nettype wire

//--- src/mulUnit.sv
`default_nettype none

`include "mdu_macros.svh"

module mulUnit import mduPkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  mulStart,
	input  wire logic                  isSigned,
	input  wire logic [`MDU_WIDTH-1:0] srcA,
	input  wire logic [`MDU_WIDTH-1:0] srcB,
	output hiLoT                       product
);

	localparam int W = `MDU_WIDTH;
	localparam int H = W / 2;

	logic [W-1:0]   magA;
	logic [W-1:0]   magB;
	logic [W-1:0]   pLL;
	logic [W-1:0]   pLH;
	logic [W-1:0]   pHL;
	logic [W-1:0]   pHH;
	logic           negRes;
	logic           s1Valid;
	logic [2*W-1:0] sum;

	// Magnitudes, -2^31 stays correct as unsigned
	assign magA = (isSigned && srcA[W-1]) ? -srcA : srcA;
	assign magB = (isSigned && srcB[W-1]) ? -srcB : srcB;

	////////////////////////////////////////
	// Stage one, partial products
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= mulStart;
		end
	end

	always_ff @(posedge clk) begin
		if (mulStart) begin
			pLL    <= magA[H-1:0] * magB[H-1:0];
			pLH    <= magA[H-1:0] * magB[W-1:H];
			pHL    <= magA[W-1:H] * magB[H-1:0];
			pHH    <= magA[W-1:H] * magB[W-1:H];
			// Result negative when exactly one operand is
			negRes <= isSigned && (srcA[W-1] ^ srcB[W-1]);
		end
	end

	////////////////////////////////////////
	// Stage two, sum and sign fix
	////////////////////////////////////////

	assign sum = {{W{1'b0}}, pLL}
		+ ({{W{1'b0}}, pLH} << H)
		+ ({{W{1'b0}}, pHL} << H)
		+ ({pHH, {W{1'b0}}});

	// Held until the next stage-one item arrives
	always_ff @(posedge clk) begin
		if (s1Valid) begin
			product <= negRes ? hiLoT'(-sum) : hiLoT'(sum);
		end
	end

endmodule

`default_nettype wire

//--- src/mduControl.sv
`default_nettype none

`include "mdu_macros.svh"

module mduControl import mduPkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   clr,
	input  wire logic   start,
	input  wire mduOpT  op,
	output logic        mulStart,
	output logic        divStart,
	output logic        divSigned,
	output logic        commit,
	output resSelT      commitSel,
	output logic        busy
);

	localparam int CntW = `MDU_CNT_WIDTH;

	// Latencies sized to the counter
	localparam logic [CntW-1:0] mulLat     = CntW'(`MDU_MUL_CYCLES);
	localparam logic [CntW-1:0] divLat     = CntW'(`MDU_DIV_CYCLES);
	localparam logic [CntW-1:0] fastDivLat = CntW'(`MDU_FASTDIV_CYCLES);

	logic [CntW-1:0] cnt;
	logic [CntW-1:0] lat;
	logic            isArith;
	logic            isMul;
	logic            accept;

	////////////////////////////////////////
	// Op decode
	////////////////////////////////////////

	always_comb begin
		isArith = 1'b1;
		isMul   = 1'b0;
		lat     = '0;
		case (op)
			opMult, opMultu: begin
				isMul = 1'b1;
				lat   = mulLat;
			end
			opDiv, opDivu: lat = divLat;
			opFastDiv:     lat = fastDivLat;
			default:       isArith = 1'b0;
		endcase
	end

	// Both signed division flavours
	assign divSigned = (op == opDiv) || (op == opFastDiv);

	////////////////////////////////////////
	// Start routing
	////////////////////////////////////////

	// Only while idle, and not while aborting
	assign accept   = start && !busy && isArith && !clr;
	assign mulStart = accept && isMul;
	assign divStart = accept && !isMul;

	////////////////////////////////////////
	// Latency counter
	////////////////////////////////////////

	// Nonzero count means an op is in flight
	assign busy = (cnt != '0);

	// Last cycle of the count, HI/LO load on the coming edge
	assign commit = (cnt == CntW'(1)) && !clr;

	always_ff @(posedge clk) begin
		if (rst || clr) begin
			cnt       <= '0;
			commitSel <= selMul;
		end else if (accept) begin
			cnt       <= lat;
			// Remembered until the commit
			commitSel <= isMul ? selMul : selDiv;
		end else if (busy) begin
			cnt <= cnt - CntW'(1);
		end
	end

endmodule

`default_nettype wire

//--- src/mduPkg.sv
`default_nettype none

`include "mdu_macros.svh"

package mduPkg;

	////////////////////////////////////////
	// Operation codes
	////////////////////////////////////////

	// Arithmetic ops start the unit, move ops touch HI/LO directly
	typedef enum logic [3:0] {
		opNone    = 4'd0,
		opMult    = 4'd1,
		opMultu   = 4'd2,
		opDiv     = 4'd3,
		opDivu    = 4'd4,
		opFastDiv = 4'd5,
		opMfhi    = 4'd6,
		opMflo    = 4'd7,
		opMthi    = 4'd8,
		opMtlo    = 4'd9
	} mduOpT;

	////////////////////////////////////////
	// Request and result bundles
	////////////////////////////////////////

	// One request from the pipeline, 68 bits
	typedef struct packed {
		mduOpT                  op;
		logic [`MDU_WIDTH-1:0] srcA;
		logic [`MDU_WIDTH-1:0] srcB;
	} mduReqT;

	// HI/LO pair, remainder in hi and quotient in lo for division
	typedef struct packed {
		logic [`MDU_WIDTH-1:0] hi;
		logic [`MDU_WIDTH-1:0] lo;
	} hiLoT;

	// Which datapath gets committed
	typedef enum logic {
		selMul = 1'b0,
		selDiv = 1'b1
	} resSelT;

endpackage

`default_nettype wire

//--- src/mdu_macros.svh
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

////////////////////////////////////////
// Datapath width
////////////////////////////////////////

// Operands, HI and LO
`define MDU_WIDTH 32

////////////////////////////////////////
// Latency per operation class
////////////////////////////////////////

// Cycles from accepted start to commit
`define MDU_MUL_CYCLES 5
`define MDU_DIV_CYCLES 10
`define MDU_FASTDIV_CYCLES 3

// Largest latency sets the counter size
`define MDU_MAX_CYCLES ((`MDU_DIV_CYCLES > `MDU_MUL_CYCLES) ? \
	((`MDU_DIV_CYCLES > `MDU_FASTDIV_CYCLES) ? `MDU_DIV_CYCLES : `MDU_FASTDIV_CYCLES) : \
	((`MDU_MUL_CYCLES > `MDU_FASTDIV_CYCLES) ? `MDU_MUL_CYCLES : `MDU_FASTDIV_CYCLES))
`define MDU_CNT_WIDTH ($clog2(`MDU_MAX_CYCLES + 1))

`endif
